//--- Bender.yml
package:
  name: ualink_turbo64

sources:
  - files:
      - ualink_pkg.sv
      - packet_fifo.sv
      - wait_timer.sv
      - reg_mem.sv
      - cmd_fsm.sv
      - ualink_turbo64.sv
  - target: test
    files:
      - ualink_turbo64_assert.sv
      - tb_ualink_turbo64.sv

//--- cmd_fsm.sv
/* command FSM between the input FIFO and the output stream
   first beat of each packet is a header, opcode in 15:8 and address in 7:0
   read packets stall the output for rd_wait cycles, then swap in the memory word
   single-beat packets are only forwarded */

`timescale 1ns/10ps

module cmd_fsm import ualink_pkg::*; #(
   parameter int rd_wait = 3
) (
   input  logic      axi_aclk,
   input  logic      axi_resetn,
   input  data_t     head_data,
   input  logic      head_last,
   input  logic      empty,
   input  logic      m_axis_tready,
   input  logic      timer_done,
   input  data_t     mem_rdata,
   output logic      pop,
   output data_t     m_axis_tdata,
   output logic      m_axis_tlast,
   output logic      m_axis_tvalid,
   output logic      timer_start,
   output logic      mem_we,
   output mem_addr_t mem_addr,
   output data_t     mem_wdata
);

   localparam logic [1:0] st_header    = 2'd0;
   localparam logic [1:0] st_body      = 2'd1;
   localparam logic [1:0] st_read_wait = 2'd2;
   localparam logic [1:0] st_read_data = 2'd3;

   logic [1:0]   state;
   logic [1:0]   state_next;
   ualink_word_u head_w;
   opcode_t      op_q;       // opcode of the packet in flight
   mem_addr_t    addr_q;     // its memory address
   logic         second_q;   // next beat out is the second of the packet
   logic         xfer;
   logic         hdr_read;

   // the timer is built with the same rd_wait, a zero stall has no state for it
   if (rd_wait < 1) begin : g_rd_wait_check
      $error("cmd_fsm: rd_wait must be at least 1");
   end

   assign head_w = head_data;   // same beat, raw and header views
   assign xfer   = m_axis_tvalid & m_axis_tready;
   assign pop    = xfer;        // head leaves the fifo as it transfers

   // multi-beat read header on its way out
   assign hdr_read = (state == st_header) & xfer & ~head_last &
                     (head_w.hdr.opcode == op_read);

   // output stream, valid dropped only while the read stall runs
   assign m_axis_tvalid = ~empty & (state != st_read_wait);
   assign m_axis_tdata  = (state == st_read_data) ? mem_rdata : head_w.raw;
   assign m_axis_tlast  = head_last;

   // address held from the header, so rdata has settled by read_data
   assign mem_addr    = addr_q;
   assign mem_wdata   = head_w.raw;
   assign mem_we      = (state == st_body) & second_q & (op_q == op_write) & xfer;
   assign timer_start = hdr_read;

   always_comb begin
      state_next = state;
      case (state)
         st_header: begin
            if (hdr_read) begin
               state_next = st_read_wait;
            end else if (xfer & ~head_last) begin
               state_next = st_body;   // write or plain packet
            end
         end
         st_body: begin
            if (xfer & head_last) begin
               state_next = st_header;
            end
         end
         st_read_wait: begin
            if (timer_done) begin
               state_next = st_read_data;
            end
         end
         st_read_data: begin
            if (xfer) begin
               state_next = head_last ? st_header : st_body;
            end
         end
         default: state_next = st_header;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state    <= st_header;
         second_q <= 1'b0;
      end else begin
         state <= state_next;
         if ((state == st_header) & xfer) begin
            second_q <= 1'b1;
         end else if (xfer) begin
            second_q <= 1'b0;   // past the second beat
         end
      end
   end

   // command fields latched as the header transfers
   always_ff @(posedge axi_aclk) begin
      if ((state == st_header) & xfer) begin
         op_q   <= head_w.hdr.opcode;
         addr_q <= head_w.hdr.addr;
      end
   end

endmodule

//--- packet_fifo.sv
/* fall-through FIFO for input beats, head word readable without a pop
   a push while nearly_full is dropped, so the writer must honour nearly_full
   nearly_full is up at two or fewer free entries */

`timescale 1ns/10ps

module packet_fifo import ualink_pkg::*; #(
   parameter int fifo_depth_bits = 5
) (
   input  logic  axi_aclk,
   input  logic  axi_resetn,
   input  logic  push,
   input  data_t push_data,
   input  logic  push_last,
   input  logic  pop,
   output data_t head_data,
   output logic  head_last,
   output logic  empty,
   output logic  nearly_full
);

   localparam int depth = 1 << fifo_depth_bits;
   localparam logic [fifo_depth_bits:0] nf_level = (fifo_depth_bits + 1)'(depth - 2);

   data_t data_mem [depth];
   logic  last_mem [depth];

   logic [fifo_depth_bits-1:0] wr_ptr;
   logic [fifo_depth_bits-1:0] rd_ptr;
   logic [fifo_depth_bits:0]   count;    // one bit wider so a full buffer is visible
   logic                       do_push;
   logic                       do_pop;

   assign do_push = push & ~nearly_full;
   assign do_pop  = pop & ~empty;

   // storage
   always_ff @(posedge axi_aclk) begin
      if (do_push) begin
         data_mem[wr_ptr] <= push_data;
         last_mem[wr_ptr] <= push_last;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   // head word straight from the array, valid one cycle after its push
   assign head_data   = data_mem[rd_ptr];
   assign head_last   = last_mem[rd_ptr];
   assign empty       = (count == '0);
   assign nearly_full = (count >= nf_level);

endmodule

//--- reg_mem.sv
/* 256 x 64 single-port register memory, one cycle read latency
   contents are undefined until written
   a read of the address being written returns the old word */

`timescale 1ns/10ps

module reg_mem import ualink_pkg::*; (
   input  logic      axi_aclk,
   input  logic      we,
   input  mem_addr_t addr,
   input  data_t     wdata,
   output data_t     rdata
);

   localparam int mem_depth = 1 << mem_addr_width;

   data_t mem [mem_depth];

   always_ff @(posedge axi_aclk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];   // registered read
   end

endmodule

//--- sim.f
ualink_pkg.sv
packet_fifo.sv
wait_timer.sv
reg_mem.sv
cmd_fsm.sv
ualink_turbo64.sv
ualink_turbo64_assert.sv
tb_ualink_turbo64.sv

//--- tb_ualink_turbo64.sv
/* random packet test of ualink_turbo64 against a model with its own memory copy
   reads only go to addresses that an earlier write packet filled, reg_mem has no reset
   rd_wait below has to match the DUT default */

`timescale 1ns/10ps

module tb_ualink_turbo64 import ualink_pkg::*; ();

   localparam int rd_wait     = 3;
   localparam int num_packets = 200;
   localparam int max_len     = 6;
   localparam int clk_period  = 10;
   localparam int timeout_ns  = num_packets * max_len * 40 * clk_period + 1000;

   logic  axi_aclk;
   logic  axi_resetn;
   data_t s_axis_tdata;
   logic  s_axis_tlast;
   logic  s_axis_tvalid;
   logic  s_axis_tready;
   data_t m_axis_tdata;
   logic  m_axis_tlast;
   logic  m_axis_tvalid;
   logic  m_axis_tready;

   logic [31:0]  rng_stim = 32'd7146;
   logic [31:0]  rng_rdy  = 32'd7146 ^ 32'h5a5a_5a5a;   // own stream for tready
   data_t        exp_data [$];
   logic         exp_last [$];
   data_t        mem_copy [256];
   bit           written [256];
   int           beat_errs, gap_errs, flag_errs, misc_errs;
   int           in_cnt, out_cnt, gap_len, waited;
   bit           first_beat, in_gap, gap_exact, saw_full;
   data_t        mon_exp_d;
   logic         mon_exp_l;
   ualink_word_u mon_w;

   initial axi_aclk = 1'b0;
   always #(clk_period / 2) axi_aclk = ~axi_aclk;

   ualink_turbo64 i_ualink_turbo64 (
      .axi_aclk     (axi_aclk),
      .axi_resetn   (axi_resetn),
      .s_axis_tdata (s_axis_tdata),
      .s_axis_tlast (s_axis_tlast),
      .s_axis_tvalid(s_axis_tvalid),
      .s_axis_tready(s_axis_tready),
      .m_axis_tdata (m_axis_tdata),
      .m_axis_tlast (m_axis_tlast),
      .m_axis_tvalid(m_axis_tvalid),
      .m_axis_tready(m_axis_tready)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_word(output data_t w);
      rng_stim = xorshift(rng_stim);
      w[63:32] = rng_stim;
      rng_stim = xorshift(rng_stim);
      w[31:0] = rng_stim;
   endtask

   task automatic check_beat(input data_t got_d, input logic got_l,
                             input data_t exp_d, input logic exp_l);
      if (got_d !== exp_d || got_l !== exp_l) begin
         beat_errs++;
         $display("Fail %0t: beat %0d is %h last %b, expected %h last %b",
                  $time, out_cnt, got_d, got_l, exp_d, exp_l);
      end
   endtask

   task automatic check_gap(input int got, input bit exact);
      if (exact ? (got != rd_wait) : (got < rd_wait)) begin
         gap_errs++;
         $display("Fail %0t: read stall of %0d cycles, expected %s%0d",
                  $time, got, exact ? "" : "at least ", rd_wait);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errs++;
         $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // hold the beat until the input handshake, then release valid
   task automatic drive_beat(input data_t d, input logic l);
      s_axis_tdata  = d;
      s_axis_tlast  = l;
      s_axis_tvalid = 1'b1;
      @(negedge axi_aclk);
      while (!s_axis_tready) @(negedge axi_aclk);
      @(posedge axi_aclk);
      #1;
      s_axis_tvalid = 1'b0;
   endtask

   task automatic send_packet();
      int           len;
      int           i;
      opcode_t      op;
      mem_addr_t    addr;
      ualink_word_u hdr;
      data_t        beats [max_len];
      data_t        exp_d;
      rng_stim = xorshift(rng_stim);
      len  = 1 + (rng_stim[15:0] % max_len);
      addr = mem_addr_t'(rng_stim[18:16] * 37);   // eight spread addresses
      case (rng_stim[21:20])
         2'd0:    op = op_write;
         2'd1:    op = op_read;
         default: begin
            op = rng_stim[31:24];
            if (op == op_read || op == op_write) op = 8'h00;
         end
      endcase
      if (op == op_read && !written[addr]) op = op_write;
      for (i = 0; i < len; i++) next_word(beats[i]);
      hdr.raw        = beats[0];
      hdr.hdr.opcode = op;
      hdr.hdr.addr   = addr;
      beats[0]       = hdr.raw;
      // model in send order
      for (i = 0; i < len; i++) begin
         exp_d = beats[i];
         if (i == 1 && op == op_write) begin
            mem_copy[addr] = beats[1];
            written[addr]  = 1'b1;
         end
         if (i == 1 && op == op_read) exp_d = mem_copy[addr];
         exp_data.push_back(exp_d);
         exp_last.push_back(i == len - 1);
      end
      for (i = 0; i < len; i++) begin
         drive_beat(beats[i], i == len - 1);
         rng_stim = xorshift(rng_stim);
         if (rng_stim[2:0] == 3'd0) begin
            repeat (1 + rng_stim[4:3]) @(posedge axi_aclk);
            #1;
         end
      end
   endtask

   // output tready, mostly high with an occasional long stop to fill the FIFO
   initial begin : ready_gen
      int   run;
      logic lvl;
      forever begin
         rng_rdy = xorshift(rng_rdy);
         if (rng_rdy[3:0] == 4'd0) begin
            lvl = 1'b0;
            run = 48;
         end else begin
            lvl = rng_rdy[4] | rng_rdy[5];
            run = 1 + rng_rdy[7:6];
         end
         @(posedge axi_aclk);
         #1 m_axis_tready = lvl;
         repeat (run - 1) @(posedge axi_aclk);
      end
   end

   // monitor, sampled mid-cycle where both sides are settled
   always @(negedge axi_aclk) begin
      if (axi_resetn) begin
         if (s_axis_tvalid && s_axis_tready) in_cnt++;
         if (!s_axis_tready) saw_full = 1'b1;
         if (in_gap) begin
            if (!m_axis_tvalid) begin
               gap_len++;
            end else begin
               check_gap(gap_len, gap_exact);
               in_gap = 1'b0;
            end
         end
         if (m_axis_tvalid && m_axis_tready) begin
            if (exp_data.size() == 0) begin
               misc_errs++;
               $display("output beat at %0t came with no packet pending", $time);
            end else begin
               mon_exp_d = exp_data.pop_front();
               mon_exp_l = exp_last.pop_front();
               check_beat(m_axis_tdata, m_axis_tlast, mon_exp_d, mon_exp_l);
               mon_w.raw = mon_exp_d;
               if (first_beat && !mon_exp_l && mon_w.hdr.opcode == op_read) begin
                  in_gap    = 1'b1;
                  gap_len   = 0;
                  gap_exact = (in_cnt >= out_cnt + 2);   // second beat already taken in
               end
               first_beat = mon_exp_l;
               out_cnt++;
            end
         end
      end
   end

   initial begin : watchdog
      #(timeout_ns);
      $display("timeout, the run did not finish within %0d ns", timeout_ns);
      $display("Testbench failed");
      $finish;
   end

   initial begin : main
      int assert_errs;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b0;
      first_beat    = 1'b1;
      repeat (4) @(posedge axi_aclk);
      #1 axi_resetn = 1'b1;
      @(negedge axi_aclk);
      check_flag("m_axis_tvalid after reset", m_axis_tvalid, 1'b0);
      check_flag("s_axis_tready after reset", s_axis_tready, 1'b1);
      @(posedge axi_aclk);
      #1;
      repeat (num_packets) send_packet();
      waited = 0;
      while (exp_data.size() != 0 && waited < 5000) begin
         @(posedge axi_aclk);
         waited++;
      end
      if (exp_data.size() != 0) begin
         misc_errs++;
         $display("%0d expected beats never came out of the DUT", exp_data.size());
      end
      repeat (20) @(negedge axi_aclk);
      if (m_axis_tvalid) begin
         misc_errs++;
         $display("the DUT still offers a beat after all packets came out");
      end
      if (!saw_full) begin
         misc_errs++;
         $display("s_axis_tready never dropped, the FIFO was never filled");
      end
      assert_errs = i_ualink_turbo64.i_ualink_turbo64_assert.fail_cnt;
      $display("errors: beat %0d, stall %0d, flag %0d, other %0d, assertion %0d",
               beat_errs, gap_errs, flag_errs, misc_errs, assert_errs);
      if (beat_errs + gap_errs + flag_errs + misc_errs + assert_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- ualink_pkg.sv
/* shared widths, opcodes and header layout for the 64-bit turbo datapath
   header layout assumes data_width is 64 and the address fits in 8 bits */

package ualink_pkg;

   localparam int data_width     = 64;
   localparam int mem_addr_width = 8;
   localparam int opcode_width   = 8;

   // payload is whatever is left above opcode and address
   localparam int payload_width  = data_width - opcode_width - mem_addr_width;

   typedef logic [data_width-1:0]     data_t;
   typedef logic [mem_addr_width-1:0] mem_addr_t;
   typedef logic [opcode_width-1:0]   opcode_t;

   localparam opcode_t op_write = 8'hEF;   // second beat goes to memory
   localparam opcode_t op_read  = 8'hEE;   // second beat replaced by memory word

   // command view of a header beat
   typedef struct packed {
      logic [payload_width-1:0] payload;   // bits 63:16, forwarded untouched
      opcode_t                  opcode;    // bits 15:8
      mem_addr_t                addr;      // bits 7:0
   } ualink_hdr_t;

   // one beat seen as plain data and as a command at the same time
   typedef union packed {
      data_t       raw;
      ualink_hdr_t hdr;
   } ualink_word_u;

endpackage

//--- ualink_turbo64.sv
/* single-queue packet path with write / read commands to a register memory
   s_axis_tready drops when the input FIFO has two or fewer free entries
   rd_wait is the read stall in cycles, at least 1 */

`timescale 1ns/10ps

module ualink_turbo64 import ualink_pkg::*; #(
   parameter int fifo_depth_bits = 5,
   parameter int rd_wait         = 3
) (
   input  logic  axi_aclk,
   input  logic  axi_resetn,
   input  data_t s_axis_tdata,
   input  logic  s_axis_tlast,
   input  logic  s_axis_tvalid,
   output logic  s_axis_tready,
   output data_t m_axis_tdata,
   output logic  m_axis_tlast,
   output logic  m_axis_tvalid,
   input  logic  m_axis_tready
);

   data_t     head_data;
   logic      head_last;
   logic      empty;
   logic      nearly_full;
   logic      push;
   logic      pop;
   logic      timer_start;
   logic      timer_done;
   logic      mem_we;
   mem_addr_t mem_addr;
   data_t     mem_wdata;
   data_t     mem_rdata;

   assign s_axis_tready = ~nearly_full;
   assign push          = s_axis_tvalid & s_axis_tready;   // input handshake

   packet_fifo #(
      .fifo_depth_bits(fifo_depth_bits)
   ) i_packet_fifo (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .push       (push),
      .push_data  (s_axis_tdata),
      .push_last  (s_axis_tlast),
      .pop        (pop),
      .head_data  (head_data),
      .head_last  (head_last),
      .empty      (empty),
      .nearly_full(nearly_full)
   );

   cmd_fsm #(
      .rd_wait(rd_wait)
   ) i_cmd_fsm (
      .axi_aclk     (axi_aclk),
      .axi_resetn   (axi_resetn),
      .head_data    (head_data),
      .head_last    (head_last),
      .empty        (empty),
      .m_axis_tready(m_axis_tready),
      .timer_done   (timer_done),
      .mem_rdata    (mem_rdata),
      .pop          (pop),
      .m_axis_tdata (m_axis_tdata),
      .m_axis_tlast (m_axis_tlast),
      .m_axis_tvalid(m_axis_tvalid),
      .timer_start  (timer_start),
      .mem_we       (mem_we),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata)
   );

   wait_timer #(
      .rd_wait(rd_wait)
   ) i_wait_timer (
      .axi_aclk  (axi_aclk),
      .axi_resetn(axi_resetn),
      .start     (timer_start),
      .done      (timer_done)
   );

   reg_mem i_reg_mem (
      .axi_aclk(axi_aclk),
      .we      (mem_we),
      .addr    (mem_addr),
      .wdata   (mem_wdata),
      .rdata   (mem_rdata)
   );

endmodule

//--- ualink_turbo64_assert.sv
/* stream hold and read stall checks, bound into ualink_turbo64
   fail_cnt counts failed assertions */

`timescale 1ns/10ps

module ualink_turbo64_assert import ualink_pkg::*; #(
   parameter int rd_wait = 3
) (
   input logic  axi_aclk,
   input logic  axi_resetn,
   input data_t m_axis_tdata,
   input logic  m_axis_tlast,
   input logic  m_axis_tvalid,
   input logic  m_axis_tready
);

   ualink_word_u out_w;
   logic         xfer;
   logic         first_q;     // next output beat is a header
   int           stall_cnt;   // cycles of forced low valid still ahead
   int           fail_cnt = 0;

   assign out_w = m_axis_tdata;
   assign xfer  = m_axis_tvalid & m_axis_tready;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         first_q   <= 1'b1;
         stall_cnt <= 0;
      end else begin
         if (xfer) first_q <= m_axis_tlast;
         if (xfer & first_q & ~m_axis_tlast & (out_w.hdr.opcode == op_read)) begin
            stall_cnt <= rd_wait;
         end else if (stall_cnt != 0) begin
            stall_cnt <= stall_cnt - 1;
         end
      end
   end

   hold_beat: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
   else begin
      fail_cnt++;
      $error("output beat changed while stalled by m_axis_tready");
   end

   read_stall: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (stall_cnt != 0) |-> !m_axis_tvalid)
   else begin
      fail_cnt++;
      $error("m_axis_tvalid high inside the read wait");
   end

endmodule

bind ualink_turbo64 ualink_turbo64_assert #(
   .rd_wait(rd_wait)
) i_ualink_turbo64_assert (
   .axi_aclk     (axi_aclk),
   .axi_resetn   (axi_resetn),
   .m_axis_tdata (m_axis_tdata),
   .m_axis_tlast (m_axis_tlast),
   .m_axis_tvalid(m_axis_tvalid),
   .m_axis_tready(m_axis_tready)
);

//--- wait_timer.sv
/* read stall timer, done rises rd_wait cycles after the start pulse
   done stays up until the next start and is low out of reset
   rd_wait must be at least 1 */

`timescale 1ns/10ps

module wait_timer #(
   parameter int rd_wait = 3
) (
   input  logic axi_aclk,
   input  logic axi_resetn,
   input  logic start,
   output logic done
);

   localparam int cnt_w = (rd_wait > 1) ? $clog2(rd_wait) : 1;
   // the load cycle itself counts as one wait cycle
   localparam logic [cnt_w-1:0] load_val = cnt_w'(rd_wait - 1);

   logic [cnt_w-1:0] cnt;
   logic             armed;   // set by the first start, keeps done low after reset

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         cnt   <= '0;
         armed <= 1'b0;
      end else if (start) begin
         cnt   <= load_val;
         armed <= 1'b1;
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign done = armed & (cnt == '0) & ~start;

endmodule
